// ==== vram_regs_config.svh ====
`ifndef VRAM_REGS_CONFIG_SVH
`define VRAM_REGS_CONFIG_SVH

// entries between the register file and the vram port
`define VRAM_QUEUE_DEPTH      4

// status word bit positions in SYS_CTRL
`define STAT_MEM_WAIT_BIT     15    // queue, port or read still in flight
`define STAT_QUEUE_FULL_BIT   14    // next request would be dropped

`endif

// ==== vram_regs_pkg.sv ====
package vram_regs_pkg;

    typedef logic [15:0] word_t;            // vram data word
    typedef logic [15:0] addr_t;            // vram word address
    typedef logic [7:0]  byte_t;            // host bus byte
    typedef logic [3:0]  mask_t;            // nibble write enables
    typedef logic [3:0]  reg_num_t;         // host register number

    // host register map, gaps read as zero
    localparam reg_num_t REG_SYS_CTRL = 4'd0;
    localparam reg_num_t REG_RD_INCR  = 4'd6;
    localparam reg_num_t REG_RD_ADDR  = 4'd7;
    localparam reg_num_t REG_WR_INCR  = 4'd8;
    localparam reg_num_t REG_WR_ADDR  = 4'd9;
    localparam reg_num_t REG_DATA     = 4'd10;
    localparam reg_num_t REG_DATA_2   = 4'd11;

    // one queued vram access, 37 bits
    typedef struct packed {
        logic  wr;                          // 1 = write, 0 = read
        mask_t mask;                        // nibble mask, writes only
        addr_t addr;                        // word address
        word_t data;                        // write data
    } vram_req_t;

endpackage

// ==== host_reg_file.sv ====
`timescale 1ns/1ps

`include "vram_regs_config.svh"

module host_reg_file (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      bus_wr_i,        // write strobe, one byte
    input  logic                      bus_rd_i,        // read strobe, one byte
    input  vram_regs_pkg::reg_num_t   bus_reg_num_i,
    input  logic                      bus_bytesel_i,   // 0 = even/high, 1 = odd/low
    input  vram_regs_pkg::byte_t      bus_data_i,
    output vram_regs_pkg::byte_t      bus_data_o,
    input  logic                      queue_full_i,
    input  logic                      queue_empty_i,
    input  logic                      port_busy_i,
    input  logic                      rd_done_i,
    input  vram_regs_pkg::word_t      rd_data_i,
    output logic                      push_o,
    output vram_regs_pkg::vram_req_t  push_req_o
);

    import vram_regs_pkg::*;

    // registered bus cycle
    logic      wr_q;
    logic      rd_q;
    reg_num_t  reg_q;
    logic      bytesel_q;
    byte_t     data_q;

    // host visible registers
    word_t     rd_incr;
    addr_t     rd_addr;
    word_t     wr_incr;
    addr_t     wr_addr;
    byte_t     data_even;                   // high byte of a pending DATA write
    mask_t     wr_mask;
    word_t     rd_word;                     // last word fetched from vram
    logic      rd_pending;

    logic      is_data_q;
    logic      wr_data_cand;
    logic      rd_addr_cand;
    logic      pre_read_cand;
    logic      read_cand;
    addr_t     rd_req_addr;
    logic      mem_wait;
    word_t     status;
    word_t     rd_mux;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end else begin
            wr_q <= bus_wr_i;
            rd_q <= bus_rd_i;
        end
    end

    always_ff @(posedge clk) begin
        reg_q     <= bus_reg_num_i;
        bytesel_q <= bus_bytesel_i;
        data_q    <= bus_data_i;
    end

    assign is_data_q     = (reg_q == REG_DATA) || (reg_q == REG_DATA_2);
    assign wr_data_cand  = wr_q && bytesel_q && is_data_q;            // odd byte completes word
    assign rd_addr_cand  = wr_q && bytesel_q && (reg_q == REG_RD_ADDR);
    assign pre_read_cand = rd_q && !wr_q && bytesel_q && is_data_q;   // fetch the next word
    assign read_cand     = rd_addr_cand || pre_read_cand;

    // a new RD_ADDR low byte is used right away
    assign rd_req_addr = rd_addr_cand ? {rd_addr[15:8], data_q} : rd_addr;

    // dropped when full, host polls the full flag
    assign push_o = (wr_data_cand || read_cand) && !queue_full_i;

    always_comb begin
        if (wr_data_cand) begin
            push_req_o.wr   = 1'b1;
            push_req_o.mask = wr_mask;
            push_req_o.addr = wr_addr;
            push_req_o.data = {data_even, data_q};
        end else begin
            push_req_o.wr   = 1'b0;
            push_req_o.mask = '0;
            push_req_o.addr = rd_req_addr;
            push_req_o.data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_incr    <= '0;
            rd_addr    <= '0;
            wr_incr    <= '0;
            wr_addr    <= '0;
            wr_mask    <= 4'b1111;
            rd_pending <= 1'b0;
        end else begin
            if (wr_q) begin
                case (reg_q)
                    REG_SYS_CTRL: begin
                        if (bytesel_q) begin
                            wr_mask <= data_q[3:0];
                        end
                    end
                    REG_RD_INCR: begin
                        if (!bytesel_q) begin
                            rd_incr[15:8] <= data_q;
                        end else begin
                            rd_incr[7:0] <= data_q;
                        end
                    end
                    REG_RD_ADDR: begin
                        if (!bytesel_q) begin
                            rd_addr[15:8] <= data_q;      // low byte below
                        end
                    end
                    REG_WR_INCR: begin
                        if (!bytesel_q) begin
                            wr_incr[15:8] <= data_q;
                        end else begin
                            wr_incr[7:0] <= data_q;
                        end
                    end
                    REG_WR_ADDR: begin
                        if (!bytesel_q) begin
                            wr_addr[15:8] <= data_q;
                        end else begin
                            wr_addr[7:0] <= data_q;
                        end
                    end
                    default: begin
                    end
                endcase
            end

            // addresses step only when the request is queued
            if (rd_addr_cand) begin
                rd_addr <= push_o ? rd_req_addr + rd_incr : rd_req_addr;
            end else if (pre_read_cand && push_o) begin
                rd_addr <= rd_addr + rd_incr;
            end
            if (wr_data_cand && push_o) begin
                wr_addr <= wr_addr + wr_incr;
            end

            if (read_cand && push_o) begin
                rd_pending <= 1'b1;
            end else if (rd_done_i) begin
                rd_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_q && !bytesel_q && is_data_q) begin
            data_even <= data_q;
        end
        if (rd_done_i) begin
            rd_word <= rd_data_i;
        end
    end

    // also covers the cycle a request is on its way into the queue
    assign mem_wait = !queue_empty_i || port_busy_i || rd_pending || push_o;

    always_comb begin
        status                       = '0;
        status[`STAT_MEM_WAIT_BIT]   = mem_wait;
        status[`STAT_QUEUE_FULL_BIT] = queue_full_i;
        status[3:0]                  = wr_mask;
    end

    always_comb begin
        case (bus_reg_num_i)
            REG_SYS_CTRL:          rd_mux = status;
            REG_RD_INCR:           rd_mux = rd_incr;
            REG_RD_ADDR:           rd_mux = rd_addr;
            REG_WR_INCR:           rd_mux = wr_incr;
            REG_WR_ADDR:           rd_mux = wr_addr;
            REG_DATA, REG_DATA_2:  rd_mux = rd_word;
            default:               rd_mux = '0;
        endcase
    end

    assign bus_data_o = bus_bytesel_i ? rd_mux[7:0] : rd_mux[15:8];

endmodule

// ==== vram_req_queue.sv ====
`timescale 1ns/1ps

`include "vram_regs_config.svh"

module vram_req_queue (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      push_i,
    input  vram_regs_pkg::vram_req_t  push_req_i,
    input  logic                      pop_i,
    output vram_regs_pkg::vram_req_t  head_o,
    output logic                      empty_o,
    output logic                      full_o
);

    import vram_regs_pkg::*;

    localparam int DEPTH = `VRAM_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    vram_req_t         mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign head_o  = mem[rd_ptr];                   // valid while not empty

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // none, or both at once
            endcase
        end
    end

endmodule

// ==== vram_access_port.sv ====
`timescale 1ns/1ps

module vram_access_port (
    input  logic                      clk,
    input  logic                      reset_i,
    input  vram_regs_pkg::vram_req_t  head_i,
    input  logic                      empty_i,
    input  vram_regs_pkg::word_t      vram_data_i,
    input  logic                      vram_ack_i,
    output logic                      pop_o,
    output logic                      busy_o,
    output logic                      vram_sel_o,
    output logic                      vram_wr_o,
    output vram_regs_pkg::mask_t      vram_wrmask_o,
    output vram_regs_pkg::addr_t      vram_addr_o,
    output vram_regs_pkg::word_t      vram_data_o,
    output logic                      rd_done_o,
    output vram_regs_pkg::word_t      rd_data_o
);

    import vram_regs_pkg::*;

    // take the head only when no cycle is open
    assign pop_o  = !vram_sel_o && !empty_i;
    assign busy_o = vram_sel_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
        end else if (vram_sel_o) begin
            if (vram_ack_i) begin
                vram_sel_o <= 1'b0;             // drop right after ack
                vram_wr_o  <= 1'b0;
            end
        end else if (pop_o) begin
            vram_sel_o <= 1'b1;
            vram_wr_o  <= head_i.wr;
        end
    end

    // held steady for the whole cycle
    always_ff @(posedge clk) begin
        if (pop_o) begin
            vram_wrmask_o <= head_i.mask;
            vram_addr_o   <= head_i.addr;
            vram_data_o   <= head_i.data;
        end
    end

    // read word goes back in the ack cycle
    assign rd_done_o = vram_sel_o && !vram_wr_o && vram_ack_i;
    assign rd_data_o = vram_data_i;

endmodule

// ==== vram_regs_top.sv ====
`timescale 1ns/1ps

module vram_regs_top (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      bus_wr_i,
    input  logic                      bus_rd_i,
    input  vram_regs_pkg::reg_num_t   bus_reg_num_i,
    input  logic                      bus_bytesel_i,
    input  vram_regs_pkg::byte_t      bus_data_i,
    output vram_regs_pkg::byte_t      bus_data_o,
    output logic                      vram_sel_o,
    output logic                      vram_wr_o,
    output vram_regs_pkg::mask_t      vram_wrmask_o,
    output vram_regs_pkg::addr_t      vram_addr_o,
    output vram_regs_pkg::word_t      vram_data_o,
    input  vram_regs_pkg::word_t      vram_data_i,
    input  logic                      vram_ack_i
);

    import vram_regs_pkg::*;

    logic       push;
    vram_req_t  push_req;
    vram_req_t  head;
    logic       queue_empty;
    logic       queue_full;
    logic       pop;
    logic       port_busy;
    logic       rd_done;
    word_t      rd_data;

    host_reg_file i_host_reg_file (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_wr_i      (bus_wr_i),
        .bus_rd_i      (bus_rd_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .queue_full_i  (queue_full),
        .queue_empty_i (queue_empty),
        .port_busy_i   (port_busy),
        .rd_done_i     (rd_done),
        .rd_data_i     (rd_data),
        .push_o        (push),
        .push_req_o    (push_req)
    );

    vram_req_queue i_vram_req_queue (
        .clk        (clk),
        .reset_i    (reset_i),
        .push_i     (push),
        .push_req_i (push_req),
        .pop_i      (pop),
        .head_o     (head),
        .empty_o    (queue_empty),
        .full_o     (queue_full)
    );

    vram_access_port i_vram_access_port (
        .clk           (clk),
        .reset_i       (reset_i),
        .head_i        (head),
        .empty_i       (queue_empty),
        .vram_data_i   (vram_data_i),
        .vram_ack_i    (vram_ack_i),
        .pop_o         (pop),
        .busy_o        (port_busy),
        .vram_sel_o    (vram_sel_o),
        .vram_wr_o     (vram_wr_o),
        .vram_wrmask_o (vram_wrmask_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_o   (vram_data_o),
        .rd_done_o     (rd_done),
        .rd_data_o     (rd_data)
    );

endmodule

// ==== vram_regs_checker.sv ====
`timescale 1ns/1ps

module vram_regs_checker (
    input logic                  clk,
    input logic                  reset_i,
    input logic                  sel_i,
    input logic                  wr_i,
    input vram_regs_pkg::mask_t  wrmask_i,
    input vram_regs_pkg::addr_t  addr_i,
    input vram_regs_pkg::word_t  data_i,
    input logic                  ack_i
);

    // open cycle keeps every vram output until ack
    property hold_until_ack;
        @(posedge clk) disable iff (reset_i)
            (sel_i && !ack_i) |=> (sel_i && $stable(wr_i) && $stable(wrmask_i)
                                   && $stable(addr_i) && $stable(data_i));
    endproperty

    property drop_after_ack;
        @(posedge clk) disable iff (reset_i)
            (sel_i && ack_i) |=> !sel_i;
    endproperty

    hold_check: assert property (hold_until_ack)
        else $error("vram outputs changed before the acknowledge");

    drop_check: assert property (drop_after_ack)
        else $error("vram select still high after the acknowledge");

    wr_sel_check: assert property (@(posedge clk) disable iff (reset_i) wr_i |-> sel_i)
        else $error("vram write high without select");

    reset_check: assert property (@(posedge clk) reset_i |=> !sel_i && !wr_i)
        else $error("vram select or write high after reset");

endmodule

bind vram_access_port vram_regs_checker i_vram_regs_checker (
    .clk      (clk),
    .reset_i  (reset_i),
    .sel_i    (vram_sel_o),
    .wr_i     (vram_wr_o),
    .wrmask_i (vram_wrmask_o),
    .addr_i   (vram_addr_o),
    .data_i   (vram_data_o),
    .ack_i    (vram_ack_i)
);

// ==== tb_vram_regs_top.sv ====
`timescale 1ns/1ps

`include "vram_regs_config.svh"

module tb_vram_regs_top;

    import vram_regs_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int TEST_WORDS      = 64;      // words moved by all behaviors, rounded up
    localparam int CYCLES_PER_WORD = 300;     // bus bytes, polling, worst ack delay
    localparam int TIMEOUT_CYCLES  = TEST_WORDS * CYCLES_PER_WORD + 800;
    localparam int POOL_SIZE       = 40;

    logic        clk;
    logic        reset_i;
    logic        bus_wr_i;
    logic        bus_rd_i;
    reg_num_t    bus_reg_num_i;
    logic        bus_bytesel_i;
    byte_t       bus_data_i;
    byte_t       bus_data_o;
    logic        vram_sel_o;
    logic        vram_wr_o;
    mask_t       vram_wrmask_o;
    addr_t       vram_addr_o;
    word_t       vram_data_o;
    word_t       vram_data_i;
    logic        vram_ack_i;

    word_t       vram_mem [65536];          // vram model contents
    word_t       shadow [65536];            // expected contents
    logic [31:0] exp_writes [$];            // {addr, merged word} in queue order
    word_t       rand_pool [POOL_SIZE];
    int          draw_idx = 0;
    int          seed = 33619;
    logic        ack_hold;                  // model withholds acknowledges

    vram_regs_top i_vram_regs_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t fill_word(input int a);
        return word_t'(a * 40503) ^ 16'h5a5a;
    endfunction

    // reference rules: nibble merge and address stepping
    function automatic word_t merged_word(input word_t old_word, input word_t new_word,
                                          input mask_t mask);
        word_t keep;
        keep = {{4{mask[3]}}, {4{mask[2]}}, {4{mask[1]}}, {4{mask[0]}}};
        return (new_word & keep) | (old_word & ~keep);
    endfunction

    function automatic addr_t step_addr(input addr_t start, input word_t incr, input int k);
        return addr_t'(32'(start) + 32'(incr) * k);
    endfunction

    function automatic word_t next_random();
        next_random = rand_pool[draw_idx % POOL_SIZE];
        draw_idx++;
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic write_byte(input reg_num_t num, input logic sel, input byte_t data);
        @(posedge clk);
        bus_wr_i      <= 1'b1;
        bus_reg_num_i <= num;
        bus_bytesel_i <= sel;
        bus_data_i    <= data;
        @(posedge clk);
        bus_wr_i      <= 1'b0;
    endtask

    task automatic read_byte(input reg_num_t num, input logic sel, output byte_t data);
        @(posedge clk);
        bus_rd_i      <= 1'b1;
        bus_reg_num_i <= num;
        bus_bytesel_i <= sel;
        @(negedge clk);
        data = bus_data_o;                  // settled mid cycle
        @(posedge clk);
        bus_rd_i      <= 1'b0;
    endtask

    task automatic write_word(input reg_num_t num, input word_t value);
        write_byte(num, 1'b0, value[15:8]);
        write_byte(num, 1'b1, value[7:0]);
    endtask

    task automatic read_word(input reg_num_t num, output word_t value);
        byte_t hi;
        byte_t lo;
        read_byte(num, 1'b0, hi);
        read_byte(num, 1'b1, lo);
        value = {hi, lo};
    endtask

    task automatic wait_idle();
        byte_t hi;
        hi = 8'hff;
        while (hi[`STAT_MEM_WAIT_BIT - 8]) begin
            read_byte(REG_SYS_CTRL, 1'b0, hi);
        end
    endtask

    task automatic wait_room();
        byte_t hi;
        hi = 8'hff;
        while (hi[`STAT_QUEUE_FULL_BIT - 8]) begin
            read_byte(REG_SYS_CTRL, 1'b0, hi);
        end
    endtask

    task automatic store_word(input reg_num_t num, input word_t value, input logic poll);
        if (poll) begin
            wait_room();
        end
        write_word(num, value);
    endtask

    task automatic expect_write(input addr_t addr, input word_t value, input mask_t mask);
        shadow[addr] = merged_word(shadow[addr], value, mask);
        exp_writes.push_back({addr, shadow[addr]});
    endtask

    // vram model with random ack latency 0 to 5 cycles
    initial begin : vram_model
        int wait_left;
        vram_ack_i  = 1'b0;
        vram_data_i = '0;
        wait_left   = -1;
        for (int a = 0; a < 65536; a++) begin
            vram_mem[addr_t'(a)] = fill_word(a);
        end
        forever begin
            @(posedge clk);
            if (vram_ack_i) begin
                vram_ack_i <= 1'b0;
                wait_left = -1;
            end else if (vram_sel_o && !ack_hold) begin
                if (wait_left < 0) begin
                    wait_left = ($random(seed) & 32'h7fff_ffff) % 6;
                end
                if (wait_left == 0) begin
                    if (vram_wr_o) begin
                        for (int n = 0; n < 4; n++) begin
                            if (vram_wrmask_o[n]) begin
                                vram_mem[vram_addr_o][4*n +: 4] = vram_data_o[4*n +: 4];
                            end
                        end
                    end else begin
                        vram_data_i <= vram_mem[vram_addr_o];
                    end
                    vram_ack_i <= 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // each acknowledged write must match the next expected one
    initial begin : write_compare
        logic [31:0] exp_entry;
        forever begin
            @(posedge clk);
            if (vram_sel_o && vram_wr_o && vram_ack_i) begin
                check_value(word_t'(exp_writes.size() != 0), 16'd1, "unexpected vram write");
                exp_entry = exp_writes.pop_front();
                check_value(vram_addr_o, exp_entry[31:16], "vram write address");
                check_value(vram_mem[vram_addr_o], exp_entry[15:0], "merged vram word");
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        word_t value;
        word_t incr;
        addr_t start;
        reset_i       = 1'b1;
        bus_wr_i      = 1'b0;
        bus_rd_i      = 1'b0;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        ack_hold      = 1'b0;
        for (int i = 0; i < POOL_SIZE; i++) begin
            rand_pool[i] = word_t'($random(seed));
        end
        for (int a = 0; a < 65536; a++) begin
            shadow[addr_t'(a)] = fill_word(a);
        end
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        read_word(REG_SYS_CTRL, value);
        check_value(value, 16'h000f, "SYS_CTRL after reset");
        read_word(REG_RD_INCR, value);
        check_value(value, '0, "RD_INCR after reset");
        read_word(REG_RD_ADDR, value);
        check_value(value, '0, "RD_ADDR after reset");
        read_word(REG_WR_INCR, value);
        check_value(value, '0, "WR_INCR after reset");
        read_word(REG_WR_ADDR, value);
        check_value(value, '0, "WR_ADDR after reset");

        incr = next_random();
        write_word(REG_RD_INCR, incr);
        read_word(REG_RD_INCR, value);
        check_value(value, incr, "RD_INCR readback");
        start = next_random();
        write_word(REG_RD_ADDR, start);
        read_word(REG_RD_ADDR, value);
        check_value(value, step_addr(start, incr, 1), "RD_ADDR steps past its pre-read");
        incr = next_random();
        write_word(REG_WR_INCR, incr);
        read_word(REG_WR_INCR, value);
        check_value(value, incr, "WR_INCR readback");
        start = next_random();
        write_word(REG_WR_ADDR, start);
        read_word(REG_WR_ADDR, value);
        check_value(value, start, "WR_ADDR readback");
        for (int r = 1; r < 16; r++) begin
            if (r < 6 || r > 11) begin
                read_word(reg_num_t'(r), value);
                check_value(value, '0, "unused register");
            end
        end
        wait_idle();

        incr  = next_random() | 16'h0001;   // odd step keeps 16 addresses distinct
        start = next_random();
        write_word(REG_WR_INCR, incr);
        write_word(REG_WR_ADDR, start);
        for (int k = 0; k < 16; k++) begin
            value = next_random();
            expect_write(step_addr(start, incr, k), value, 4'b1111);
            store_word(k[0] ? REG_DATA_2 : REG_DATA, value, 1'b1);
        end
        wait_idle();
        read_word(REG_WR_ADDR, value);
        check_value(value, step_addr(start, incr, 16), "WR_ADDR after 16 writes");
        check_value(word_t'(exp_writes.size()), '0, "writes never reached the vram");

        write_word(REG_RD_INCR, incr);
        write_word(REG_RD_ADDR, start);
        for (int k = 0; k < 16; k++) begin
            wait_idle();
            read_word(REG_DATA, value);
            check_value(value, shadow[step_addr(start, incr, k)], "DATA read sequence");
        end
        wait_idle();

        write_byte(REG_SYS_CTRL, 1'b1, 8'h05);
        read_word(REG_SYS_CTRL, value);
        check_value(value & 16'h000f, 16'h0005, "write mask readback");
        start = next_random();
        write_word(REG_WR_ADDR, start);
        value = next_random();
        expect_write(start, value, 4'b0101);
        store_word(REG_DATA, value, 1'b1);
        write_byte(REG_SYS_CTRL, 1'b1, 8'h0f);
        write_word(REG_RD_ADDR, start);
        wait_idle();
        read_word(REG_DATA, value);
        check_value(value, shadow[start], "masked word readback");

        // stalled pre-read keeps the port busy so the fifth write is dropped
        ack_hold <= 1'b1;
        start = next_random();
        write_word(REG_WR_INCR, 16'h0001);
        write_word(REG_WR_ADDR, start);
        for (int k = 0; k < 5; k++) begin
            value = next_random();
            if (k < 4) begin
                expect_write(step_addr(start, 16'h0001, k), value, 4'b1111);
            end
            store_word(REG_DATA, value, 1'b0);
            read_word(REG_SYS_CTRL, incr);
            check_value(word_t'(incr[`STAT_QUEUE_FULL_BIT]), word_t'(k >= 3), "queue-full flag");
        end
        read_word(REG_WR_ADDR, value);
        check_value(value, step_addr(start, 16'h0001, 4), "WR_ADDR skips the dropped write");
        ack_hold <= 1'b0;
        wait_idle();
        check_value(word_t'(exp_writes.size()), '0, "queued writes lost");
        write_word(REG_RD_ADDR, step_addr(start, 16'h0001, 4));
        wait_idle();
        read_word(REG_DATA, value);
        check_value(value, shadow[step_addr(start, 16'h0001, 4)], "dropped write left memory");

        if (exp_writes.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("writes queued by the host never reached the vram");
            $display("Regression failed");
            $fatal(1, "pending writes at the end of the run");
        end
    end

endmodule

// ==== vram_regs_top.f ====
+incdir+.
vram_regs_pkg.sv
host_reg_file.sv
vram_req_queue.sv
vram_access_port.sv
vram_regs_top.sv
vram_regs_checker.sv
tb_vram_regs_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_vram_regs_top
FILELIST = vram_regs_top.f
BUILD    = obj_dir
PASS_MSG = Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
